// ==== hw/mandel_pkg.sv ====
/*
 * mandelbrot shared definitions
 * fixed-point format, colour index type and the FSM state encodings
 */
package mandel_pkg;

    // fixed-point format, signed 4.21
    localparam int FP_WIDTH   = 25;                 // total bits
    localparam int FP_INT     = 4;                  // integer bits incl sign
    localparam int FP_FRAC    = FP_WIDTH - FP_INT;  // 21 fraction bits
    localparam int CIDX_WIDTH = 8;                  // colour index bits

    typedef logic signed [FP_WIDTH-1:0] fp_t;  // coordinate, step or product term
    typedef logic [CIDX_WIDTH-1:0] cidx_t;     // escape count used as colour index

    // escape threshold for x^2 + y^2
    localparam fp_t FP_FOUR = fp_t'(4 << FP_FRAC);

    // navigation mode, also a status output
    typedef enum logic [1:0] {
        MODE_HORIZONTAL,  // up/dn pan x
        MODE_VERTICAL,    // up/dn pan y
        MODE_ZOOM         // up zooms out, dn zooms in
    } view_mode_t;

    // iteration engine
    typedef enum logic [1:0] {
        ITER_IDLE,
        ITER_MULTIPLY,  // register x*x, y*y, x*y
        ITER_UPDATE     // escape test or z update
    } iter_state_t;

    // raster scanner
    typedef enum logic [1:0] {
        RENDER_IDLE,
        RENDER_LAUNCH,  // kick engine for current pixel
        RENDER_WAIT     // wait for engine done
    } render_state_t;

endpackage

// ==== hw/view_control.sv ====
/*
 * view control: turns mode/up/down pulses into a new view origin and step,
 * checks the zoom limit and issues a render start per accepted change
 */
`timescale 1ns/1ps

module view_control #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180,
    parameter mandel_pkg::fp_t X_START = 25'h1900000,  // -3.5
    parameter mandel_pkg::fp_t Y_START = 25'h1D00000,  // -1.5
    parameter mandel_pkg::fp_t STEP    = 25'h0008000   // 1/64, also the largest step
) (
    input  logic                   clk_sys,
    input  logic                   rst_sys,
    input  logic                   btn_mode,   // single-cycle pulses
    input  logic                   btn_up,
    input  logic                   btn_dn,
    input  logic                   busy,       // renderer running
    output mandel_pkg::fp_t        x_start,    // committed view, stable while busy
    output mandel_pkg::fp_t        y_start,
    output mandel_pkg::fp_t        step,
    output logic                   start,      // one-cycle render start
    output mandel_pkg::view_mode_t view_mode
);

    // zoom offsets in pixels, in fp_t so the products wrap at 25 bits
    localparam mandel_pkg::fp_t ZIN_X  = mandel_pkg::fp_t'(FB_WIDTH / 4);
    localparam mandel_pkg::fp_t ZIN_Y  = mandel_pkg::fp_t'(FB_HEIGHT / 4);
    localparam mandel_pkg::fp_t ZOUT_X = mandel_pkg::fp_t'(FB_WIDTH / 2);
    localparam mandel_pkg::fp_t ZOUT_Y = mandel_pkg::fp_t'(FB_HEIGHT / 2);

    mandel_pkg::fp_t x_next, y_next, step_next;  // view after this button
    mandel_pkg::fp_t x_prop, y_prop, step_prop;  // registered proposal
    mandel_pkg::view_mode_t mode_next;
    logic move;            // up or dn this cycle
    logic changed;         // proposal waiting for commit
    logic render_pending;  // start owed to the renderer
    logic accept;          // buttons are looked at

    // a pending commit or an owed start counts as a change in flight
    assign accept = !busy && !changed && !render_pending && !start;
    assign move   = btn_up || btn_dn;

    // proposed view from current view and buttons, up wins over dn
    always_comb begin
        x_next    = x_start;
        y_next    = y_start;
        step_next = step;
        mode_next = mandel_pkg::MODE_HORIZONTAL;
        case (view_mode)
            mandel_pkg::MODE_HORIZONTAL: begin
                if (btn_up) x_next = x_start - (step <<< 4);       // 16 px left
                else if (btn_dn) x_next = x_start + (step <<< 4);  // 16 px right
                mode_next = mandel_pkg::MODE_VERTICAL;
            end
            mandel_pkg::MODE_VERTICAL: begin
                if (btn_up) y_next = y_start - (step <<< 4);
                else if (btn_dn) y_next = y_start + (step <<< 4);
                mode_next = mandel_pkg::MODE_ZOOM;
            end
            mandel_pkg::MODE_ZOOM: begin
                if (btn_up) begin  // zoom out around centre
                    x_next    = x_start - step * ZOUT_X;
                    y_next    = y_start - step * ZOUT_Y;
                    step_next = step <<< 1;
                end else if (btn_dn) begin  // zoom in around centre
                    x_next    = x_start + step * ZIN_X;
                    y_next    = y_start + step * ZIN_Y;
                    step_next = step >>> 1;
                end
                mode_next = mandel_pkg::MODE_HORIZONTAL;
            end
            default: mode_next = mandel_pkg::MODE_HORIZONTAL;
        endcase
    end

    // proposal register
    always_ff @(posedge clk_sys) begin
        if (accept && move) begin
            x_prop    <= x_next;
            y_prop    <= y_next;
            step_prop <= step_next;
        end
    end

    // mode, commit and start sequencing
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            view_mode      <= mandel_pkg::MODE_HORIZONTAL;
            x_start        <= X_START;
            y_start        <= Y_START;
            step           <= STEP;
            changed        <= 1'b0;
            render_pending <= 1'b1;  // initial render after reset
            start          <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                if (move) changed <= 1'b1;
                if (btn_mode) view_mode <= mode_next;  // same cycle as a move
            end

            if (changed && !busy) begin
                changed <= 1'b0;
                // too far in or out: keep old view, no render
                if (step_prop != '0 && step_prop <= STEP) begin
                    x_start        <= x_prop;
                    y_start        <= y_prop;
                    step           <= step_prop;
                    render_pending <= 1'b1;
                end
            end else if (render_pending) begin
                start          <= 1'b1;
                render_pending <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/mandel_iter.sv ====
/*
 * mandelbrot iteration engine: escape count of one point c = cx + i*cy,
 * two cycles per iteration in signed 4.21 fixed point
 */
`timescale 1ns/1ps

module mandel_iter #(
    parameter int ITER_MAX = 255  // at most 255
) (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              start,  // latch cx/cy and begin
    input  mandel_pkg::fp_t   cx,
    input  mandel_pkg::fp_t   cy,
    output logic              done,   // one-cycle, cidx valid with it
    output mandel_pkg::cidx_t cidx
);

    localparam mandel_pkg::cidx_t N_LAST = mandel_pkg::cidx_t'(ITER_MAX);
    localparam int PW = 2 * mandel_pkg::FP_WIDTH;  // full product width

    mandel_pkg::iter_state_t state;
    mandel_pkg::fp_t c_re, c_im;  // latched point
    mandel_pkg::fp_t x, y;        // z
    mandel_pkg::fp_t xx, yy, xy;  // registered scaled products
    mandel_pkg::fp_t mag;         // x^2 + y^2, wraps
    mandel_pkg::cidx_t n;         // iteration count
    logic signed [PW-1:0] xx_full, yy_full, xy_full;
    logic stop;                   // escaped or out of iterations
    logic fin;                    // stop seen, done next cycle

    always_comb begin
        xx_full = x * x;
        yy_full = y * y;
        xy_full = x * y;
        mag     = xx + yy;
        stop    = (mag > mandel_pkg::FP_FOUR) || (n == N_LAST);
    end

    // state and done
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= mandel_pkg::ITER_IDLE;
            fin   <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= fin;
            fin  <= 1'b0;
            case (state)
                mandel_pkg::ITER_IDLE: begin
                    if (start) state <= mandel_pkg::ITER_MULTIPLY;
                end
                mandel_pkg::ITER_MULTIPLY: state <= mandel_pkg::ITER_UPDATE;
                mandel_pkg::ITER_UPDATE: begin
                    if (stop) begin
                        fin   <= 1'b1;
                        state <= mandel_pkg::ITER_IDLE;
                    end else begin
                        state <= mandel_pkg::ITER_MULTIPLY;
                    end
                end
                default: state <= mandel_pkg::ITER_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_sys) begin
        case (state)
            mandel_pkg::ITER_IDLE: begin
                if (start) begin
                    c_re <= cx;
                    c_im <= cy;
                    x    <= '0;  // z0 = 0
                    y    <= '0;
                    n    <= '0;
                end
            end
            mandel_pkg::ITER_MULTIPLY: begin
                // back to 4.21, drop upper bits
                xx <= mandel_pkg::fp_t'(xx_full >>> mandel_pkg::FP_FRAC);
                yy <= mandel_pkg::fp_t'(yy_full >>> mandel_pkg::FP_FRAC);
                xy <= mandel_pkg::fp_t'(xy_full >>> mandel_pkg::FP_FRAC);
            end
            mandel_pkg::ITER_UPDATE: begin
                if (!stop) begin
                    x <= xx - yy + c_re;       // re(z^2) + cx
                    y <= (xy <<< 1) + c_im;    // im(z^2) + cy
                    n <= n + 1'b1;
                end
            end
            default: ;
        endcase
        if (fin) cidx <= n;  // n is held once stop is seen
    end

endmodule

// ==== hw/mandel_render.sv ====
/*
 * mandelbrot renderer: raster scan of the framebuffer, one point
 * through the iteration engine at a time, escape count written per pixel
 */
`timescale 1ns/1ps

module mandel_render #(
    parameter  int FB_WIDTH  = 320,
    parameter  int FB_HEIGHT = 180,
    parameter  int ITER_MAX  = 255,
    localparam int ADDRW     = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              start,       // begin a frame
    input  mandel_pkg::fp_t   x_start,     // top-left point
    input  mandel_pkg::fp_t   y_start,
    input  mandel_pkg::fp_t   step,        // distance between pixels
    output logic              busy,
    output logic              we,          // framebuffer write strobe
    output logic [ADDRW-1:0]  addr_write,
    output mandel_pkg::cidx_t cidx         // write data
);

    localparam int XW = $clog2(FB_WIDTH);
    localparam int YW = $clog2(FB_HEIGHT);
    localparam logic [XW-1:0] X_LAST = XW'(FB_WIDTH - 1);
    localparam logic [YW-1:0] Y_LAST = YW'(FB_HEIGHT - 1);

    mandel_pkg::render_state_t state;
    logic [XW-1:0] px;           // column
    logic [YW-1:0] py;           // row
    logic [ADDRW-1:0] pix_addr;  // address of px/py
    mandel_pkg::fp_t cx, cy;     // point of px/py, stepped not multiplied
    logic iter_start, iter_done;
    mandel_pkg::cidx_t iter_cidx;
    logic last_pixel;

    assign last_pixel = (px == X_LAST) && (py == Y_LAST);

    mandel_iter #(
        .ITER_MAX(ITER_MAX)
    ) iter_inst (
        .clk_sys,
        .rst_sys,
        .start(iter_start),
        .cx,
        .cy,
        .done(iter_done),
        .cidx(iter_cidx)
    );

    // FSM
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state      <= mandel_pkg::RENDER_IDLE;
            busy       <= 1'b0;
            we         <= 1'b0;
            iter_start <= 1'b0;
        end else begin
            we         <= 1'b0;
            iter_start <= 1'b0;
            case (state)
                mandel_pkg::RENDER_IDLE: begin
                    busy <= start;  // drops the cycle after the last write
                    if (start) state <= mandel_pkg::RENDER_LAUNCH;
                end
                mandel_pkg::RENDER_LAUNCH: begin
                    iter_start <= 1'b1;
                    state      <= mandel_pkg::RENDER_WAIT;
                end
                mandel_pkg::RENDER_WAIT: begin
                    if (iter_done) begin
                        we    <= 1'b1;
                        state <= last_pixel ? mandel_pkg::RENDER_IDLE
                                            : mandel_pkg::RENDER_LAUNCH;
                    end
                end
                default: state <= mandel_pkg::RENDER_IDLE;
            endcase
        end
    end

    // raster counters and write data
    always_ff @(posedge clk_sys) begin
        if (state == mandel_pkg::RENDER_IDLE && start) begin
            px       <= '0;
            py       <= '0;
            pix_addr <= '0;
            cx       <= x_start;
            cy       <= y_start;
        end else if (state == mandel_pkg::RENDER_WAIT && iter_done) begin
            addr_write <= pix_addr;
            cidx       <= iter_cidx;
            pix_addr   <= pix_addr + 1'b1;  // raster order, no gaps
            if (px == X_LAST) begin         // next row
                px <= '0;
                py <= py + 1'b1;
                cx <= x_start;
                cy <= cy + step;
            end else begin
                px <= px + 1'b1;
                cx <= cx + step;
            end
        end
    end

endmodule

// ==== hw/bram_sdp.sv ====
/*
 * simple dual-port framebuffer RAM, one write port and one registered read port
 */
`timescale 1ns/1ps

module bram_sdp #(
    parameter  int DEPTH = 57600,          // entries
    localparam int ADDRW = $clog2(DEPTH)
) (
    input  logic              clk_sys,
    input  logic              we,
    input  logic [ADDRW-1:0]  addr_write,
    input  logic [ADDRW-1:0]  addr_read,
    input  mandel_pkg::cidx_t data_in,
    output mandel_pkg::cidx_t data_out   // one clock after addr_read
);

    mandel_pkg::cidx_t mem [DEPTH];

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // old data on a same-address collision
    end

endmodule

// ==== hw/mandel_top.sv ====
/*
 * mandelbrot subsystem top: view control, renderer and framebuffer RAM
 */
`timescale 1ns/1ps

module mandel_top #(
    parameter  int FB_WIDTH  = 320,
    parameter  int FB_HEIGHT = 180,
    parameter  int ITER_MAX  = 255,
    parameter  mandel_pkg::fp_t X_START = 25'h1900000,  // -3.5
    parameter  mandel_pkg::fp_t Y_START = 25'h1D00000,  // -1.5
    parameter  mandel_pkg::fp_t STEP    = 25'h0008000,  // 1/64
    localparam int ADDRW = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic                   clk_sys,
    input  logic                   rst_sys,
    input  logic                   btn_mode,
    input  logic                   btn_up,
    input  logic                   btn_dn,
    input  logic [ADDRW-1:0]       fb_addr_read,
    output mandel_pkg::cidx_t      fb_colr_read,
    output logic                   render_busy,
    output mandel_pkg::view_mode_t view_mode
);

    mandel_pkg::fp_t x_start, y_start, step;  // committed view
    logic render_start;
    logic fb_we;
    logic [ADDRW-1:0] fb_addr_write;
    mandel_pkg::cidx_t fb_colr_write;

    view_control #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .X_START(X_START),
        .Y_START(Y_START),
        .STEP(STEP)
    ) control_inst (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .busy(render_busy),
        .x_start,
        .y_start,
        .step,
        .start(render_start),
        .view_mode
    );

    mandel_render #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .ITER_MAX(ITER_MAX)
    ) render_inst (
        .clk_sys,
        .rst_sys,
        .start(render_start),
        .x_start,
        .y_start,
        .step,
        .busy(render_busy),
        .we(fb_we),
        .addr_write(fb_addr_write),
        .cidx(fb_colr_write)
    );

    bram_sdp #(
        .DEPTH(FB_WIDTH * FB_HEIGHT)
    ) fb_inst (
        .clk_sys,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .addr_read(fb_addr_read),
        .data_in(fb_colr_write),
        .data_out(fb_colr_read)
    );

endmodule

// ==== test/tb_mandel.sv ====
/*
 * testbench for the mandelbrot subsystem: steps a small view through pans,
 * mode changes and zooms, checks every framebuffer pixel against a reference
 */
`timescale 1ns/1ps

module tb_mandel;

    localparam int FB_WIDTH   = 32;
    localparam int FB_HEIGHT  = 18;
    localparam int ITER_MAX   = 31;
    localparam int PIXELS     = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW      = $clog2(PIXELS);
    localparam int CLK_PERIOD = 10;  // ns

    typedef logic signed [24:0] fix_t;  // signed 4.21

    localparam fix_t STEP    = 25'h0040000;  // 1/8, also the widest step
    localparam fix_t X_START = 25'h1B00000;  // -2.5
    localparam fix_t Y_START = 25'h1DC0000;  // -1.125
    localparam fix_t FOUR    = 25'h0800000;  // escape radius squared

    // 12 worst case renders plus room for frame reads and idle checks
    localparam int WATCHDOG_NS = (12 * PIXELS * (2 * ITER_MAX + 6) + 50000) * CLK_PERIOD;

    logic clk_sys;
    logic rst_sys;
    logic btn_mode;
    logic btn_up;
    logic btn_dn;
    logic [ADDRW-1:0] fb_addr_read;
    logic [7:0] fb_colr_read;
    logic render_busy;
    mandel_pkg::view_mode_t view_mode;

    // view model kept by the testbench
    fix_t m_x;
    fix_t m_y;
    fix_t m_step;
    mandel_pkg::view_mode_t m_mode;

    logic sweep_on;              // frame read in progress
    logic [ADDRW-1:0] rd_addr_q; // address seen by the RAM
    logic rd_valid_q = 1'b0;
    integer seed = 32'h6d7f298d;

    mandel_top #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .ITER_MAX(ITER_MAX),
        .X_START(X_START),
        .Y_START(Y_START),
        .STEP(STEP)
    ) dut0 (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .fb_addr_read,
        .fb_colr_read,
        .render_busy,
        .view_mode
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // escape count of c = cx + i*cy, z starts at 0, all sums wrap at 25 bits
    function automatic logic [7:0] ref_cidx(input fix_t cx, input fix_t cy);
        logic signed [49:0] full_xx, full_yy, full_xy;
        fix_t x, y, xx, yy, xy, mag;
        int n;
        logic fin;
        x = '0;
        y = '0;
        n = 0;
        fin = 1'b0;
        while (!fin) begin
            full_xx = 50'(x) * 50'(x);
            full_yy = 50'(y) * 50'(y);
            full_xy = 50'(x) * 50'(y);
            xx = fix_t'(full_xx >>> 21);  // back to 4.21, upper bits dropped
            yy = fix_t'(full_yy >>> 21);
            xy = fix_t'(full_xy >>> 21);
            mag = xx + yy;
            if (mag > FOUR || n == ITER_MAX) begin
                fin = 1'b1;
            end else begin
                x = xx - yy + cx;
                y = xy + xy + cy;  // 2xy
                n++;
            end
        end
        return 8'(n);
    endfunction

    // colour expected at a framebuffer address for the model view
    function automatic logic [7:0] expected_pixel(input int addr);
        int px, py;
        fix_t cx, cy;
        px = addr % FB_WIDTH;
        py = addr / FB_WIDTH;  // rows top to bottom
        cx = m_x + fix_t'(px) * m_step;
        cy = m_y + fix_t'(py) * m_step;
        return ref_cidx(cx, cy);
    endfunction

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    // address and valid as the RAM samples them
    always @(posedge clk_sys) begin
        rd_addr_q  <= fb_addr_read;
        rd_valid_q <= sweep_on;
    end

    // read data is stable here, one clock after its address
    always @(negedge clk_sys) begin : compare_read
        logic [7:0] exp_colr;
        if (rd_valid_q) begin
            exp_colr = expected_pixel(int'(rd_addr_q));
            assert (fb_colr_read == exp_colr)
                else begin
                    $display("FAIL fb_colr_read addr %h expected %h actual %h",
                             rd_addr_q, exp_colr, fb_colr_read);
                    stop_with_failure();
                end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("a render did not finish within the time limit");
        stop_with_failure();
    end

    // one-cycle button pulse, set and cleared on falling edges
    task automatic pulse_buttons(input logic mode, input logic up, input logic dn);
        @(negedge clk_sys);
        btn_mode = mode;
        btn_up   = up;
        btn_dn   = dn;
        @(negedge clk_sys);
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
    endtask

    task automatic expect_render_start(input int limit);
        int waited;
        waited = 0;
        while (!render_busy && waited < limit) begin
            @(negedge clk_sys);
            waited++;
        end
        assert (render_busy)
            else begin
                $display("render did not start within %0d cycles", limit);
                stop_with_failure();
            end
    endtask

    task automatic expect_no_render(input int cycles);
        repeat (cycles) begin
            @(negedge clk_sys);
            assert (!render_busy)
                else begin
                    $display("a render started although no view change was accepted");
                    stop_with_failure();
                end
        end
    endtask

    // wait for the frame, then read it back in full
    task automatic compare_frame();
        int a;
        while (render_busy) @(negedge clk_sys);
        for (a = 0; a < PIXELS; a++) begin
            @(negedge clk_sys);
            fb_addr_read = ADDRW'(a);
            sweep_on     = 1'b1;
        end
        @(negedge clk_sys);
        sweep_on = 1'b0;  // last address checked on this edge
        @(negedge clk_sys);
    endtask

    // apply an up/dn press to the model view, up wins over dn
    task automatic model_move(input logic up, input logic dn, output logic accepted);
        fix_t nx, ny, ns;
        nx = m_x;
        ny = m_y;
        ns = m_step;
        case (m_mode)
            mandel_pkg::MODE_HORIZONTAL: begin
                if (up) nx = m_x - fix_t'(16) * m_step;
                else if (dn) nx = m_x + fix_t'(16) * m_step;
            end
            mandel_pkg::MODE_VERTICAL: begin
                if (up) ny = m_y - fix_t'(16) * m_step;
                else if (dn) ny = m_y + fix_t'(16) * m_step;
            end
            default: begin
                if (up) begin  // zoom out
                    nx = m_x - fix_t'(FB_WIDTH / 2) * m_step;
                    ny = m_y - fix_t'(FB_HEIGHT / 2) * m_step;
                    ns = m_step + m_step;
                end else if (dn) begin  // zoom in
                    nx = m_x + fix_t'(FB_WIDTH / 4) * m_step;
                    ny = m_y + fix_t'(FB_HEIGHT / 4) * m_step;
                    ns = m_step >>> 1;
                end
            end
        endcase
        accepted = (up || dn) && ns != '0 && ns <= STEP;
        if (accepted) begin
            m_x    = nx;
            m_y    = ny;
            m_step = ns;
        end
    endtask

    // press up or dn, then check the new frame or the lack of a render
    task automatic navigate(input logic up, input logic dn, output logic accepted);
        model_move(up, dn, accepted);
        pulse_buttons(1'b0, up, dn);
        if (accepted) expect_render_start(4);
        else expect_no_render(8);
        compare_frame();
    endtask

    task automatic change_mode(input mandel_pkg::view_mode_t next);
        pulse_buttons(1'b1, 1'b0, 1'b0);
        m_mode = next;
        assert (view_mode == next)
            else begin
                $display("FAIL view_mode expected %h actual %h", next, view_mode);
                stop_with_failure();
            end
        expect_no_render(8);  // mode alone never renders
    endtask

    initial begin : main
        logic accepted;
        int delay;
        clk_sys      = 1'b0;
        rst_sys      = 1'b1;
        btn_mode     = 1'b0;
        btn_up       = 1'b0;
        btn_dn       = 1'b0;
        fb_addr_read = '0;
        sweep_on     = 1'b0;
        m_x          = X_START;
        m_y          = Y_START;
        m_step       = STEP;
        m_mode       = mandel_pkg::MODE_HORIZONTAL;

        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        assert (!render_busy && view_mode == mandel_pkg::MODE_HORIZONTAL)
            else begin
                $display("outputs not at their reset values during reset");
                stop_with_failure();
            end
        rst_sys = 1'b0;

        // starting view
        expect_render_start(4);
        compare_frame();

        // pans, x then y
        navigate(1'b1, 1'b0, accepted);
        navigate(1'b0, 1'b1, accepted);
        change_mode(mandel_pkg::MODE_VERTICAL);
        navigate(1'b1, 1'b0, accepted);
        navigate(1'b0, 1'b1, accepted);

        // full trip round the modes, ends in zoom
        change_mode(mandel_pkg::MODE_ZOOM);
        change_mode(mandel_pkg::MODE_HORIZONTAL);
        change_mode(mandel_pkg::MODE_VERTICAL);
        change_mode(mandel_pkg::MODE_ZOOM);

        // in, then back out to the widest step
        navigate(1'b0, 1'b1, accepted);
        navigate(1'b1, 1'b0, accepted);

        // one more zoom out goes past the widest step
        navigate(1'b1, 1'b0, accepted);

        // press during a render is dropped
        model_move(1'b0, 1'b1, accepted);
        pulse_buttons(1'b0, 1'b0, 1'b1);
        expect_render_start(4);
        delay = 2 + ($unsigned($random(seed)) % 64);
        repeat (delay) @(negedge clk_sys);
        assert (render_busy)
            else begin
                $display("render ended before the button could be pressed");
                stop_with_failure();
            end
        pulse_buttons(1'b0, 1'b1, 1'b0);
        compare_frame();  // model left as before the press
        expect_no_render(8);

        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/mandel_pkg.sv
hw/view_control.sv
hw/mandel_iter.sv
hw/mandel_render.sv
hw/bram_sdp.sv
hw/mandel_top.sv
test/tb_mandel.sv

// ==== Makefile ====
# Verilator flow for the mandelbrot subsystem testbench
TOP := tb_mandel

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f

# pass only if the simulation printed the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "test passed"

lint:
	verilator --lint-only -Wall --top-module mandel_top hw/mandel_pkg.sv hw/view_control.sv \
		hw/mandel_iter.sv hw/mandel_render.sv hw/bram_sdp.sv hw/mandel_top.sv
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
